//--- design/jumpCorePkg.sv
package jumpCorePkg;

  // fetch address width
  localparam int addrW = 64;

  typedef logic [addrW-1:0] addrT;

  // return stack geometry, depth is a power of two
  localparam int rasDepth = 8;
  localparam int rasPtrW  = 3;

  // kind of control transfer
  typedef enum logic [3:0] {
    jkNone,
    jkBeq,
    jkBne,
    jkBlt,
    jkBge,
    jkBltu,
    jkBgeu,
    jkJal,
    jkJalr
  } jumpKindT;

  // four-phase handshake states
  typedef enum logic [1:0] {
    hsIdle,
    hsDecode,
    hsAck,
    hsRelease
  } hsStateT;

endpackage

//--- design/jumpDecoder.sv
`timescale 1ns/100ps

module jumpDecoder (
  input  logic [riscvIsaPkg::instrW-1:0] instr,
  input  logic                           mode64,
  output jumpCorePkg::jumpKindT          kind,
  output jumpCorePkg::addrT              imm,
  output logic                           isCall,
  output logic                           isReturn,
  output logic                           compressed
);
  import riscvIsaPkg::*;
  import jumpCorePkg::*;

  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] cRs1;
  addrT       bImm;
  addrT       jImm;
  addrT       iImm;
  addrT       cjImm;
  addrT       cbImm;

  function automatic logic isLinkReg(input logic [4:0] r);
    return (r == linkRegA) || (r == linkRegB);
  endfunction

  assign compressed = (instr[1:0] != quadFull);

  // register fields, 32-bit and compressed
  assign rd   = instr[11:7];
  assign rs1  = instr[19:15];
  assign cRs1 = instr[11:7];

  // 32-bit immediates
  assign bImm = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign jImm = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign iImm = {{52{instr[31]}}, instr[31:20]};

  // compressed immediates, scrambled bit order per the C extension
  assign cjImm = {{52{instr[12]}}, instr[12], instr[8], instr[10:9], instr[6], instr[7],
                  instr[2], instr[11], instr[5:3], 1'b0};
  assign cbImm = {{55{instr[12]}}, instr[12], instr[6:5], instr[2], instr[11:10],
                  instr[4:3], 1'b0};

  always_comb begin
    kind     = jkNone;
    imm      = '0;
    isCall   = 1'b0;
    isReturn = 1'b0;
    if (!compressed) begin
      case (instr[6:0])
        opBranch: begin
          imm = bImm;
          case (instr[14:12])
            f3Beq:   kind = jkBeq;
            f3Bne:   kind = jkBne;
            f3Blt:   kind = jkBlt;
            f3Bge:   kind = jkBge;
            f3Bltu:  kind = jkBltu;
            f3Bgeu:  kind = jkBgeu;
            default: kind = jkNone;
          endcase
        end
        opJal: begin
          kind   = jkJal;
          imm    = jImm;
          isCall = isLinkReg(rd);
        end
        opJalr: begin
          if (instr[14:12] == jalrFunct3) begin
            kind   = jkJalr;
            imm    = iImm;
            isCall = isLinkReg(rd);
            // same link register in rd and rs1 is a plain call
            isReturn = isLinkReg(rs1) && (!isLinkReg(rd) || (rd != rs1));
          end
        end
        default: kind = jkNone;
      endcase
    end else if (instr[1:0] == quadC1) begin
      case (instr[15:13])
        cJal: begin
          // c.addiw in RV64
          if (!mode64) begin
            kind   = jkJal;
            imm    = cjImm;
            isCall = 1'b1;
          end
        end
        cJ: begin
          kind = jkJal;
          imm  = cjImm;
        end
        cBeqz: begin
          kind = jkBeq;
          imm  = cbImm;
        end
        cBnez: begin
          kind = jkBne;
          imm  = cbImm;
        end
        default: kind = jkNone;
      endcase
    end else if ((instr[1:0] == quadC2) && (instr[15:13] == cJrMv)) begin
      // rs2 must be zero, otherwise c.mv / c.add
      if ((instr[6:2] == 5'd0) && (cRs1 != 5'd0)) begin
        kind = jkJalr;
        if (instr[12]) begin
          // c.jalr, implicit rd is ra
          isCall   = 1'b1;
          isReturn = isLinkReg(cRs1) && (cRs1 != linkRegA);
        end else begin
          isReturn = isLinkReg(cRs1);
        end
      end
    end
  end

endmodule

//--- design/jumpHandshake.sv
`timescale 1ns/100ps

module jumpHandshake (
  input  logic                           clk,
  input  logic                           arstN,
  input  logic                           req,
  input  jumpCorePkg::addrT              pcIn,
  input  logic [riscvIsaPkg::instrW-1:0] instrIn,
  input  logic                           mode64In,
  output logic                           ack,
  output logic                           calcEn,
  output logic                           rasUpdate,
  output jumpCorePkg::addrT              pcReg,
  output logic [riscvIsaPkg::instrW-1:0] instrReg,
  output logic                           mode64Reg
);
  import jumpCorePkg::*;

  hsStateT state;
  hsStateT stateNext;

  always_comb begin
    stateNext = state;
    case (state)
      hsIdle:    if (req) stateNext = hsDecode;
      hsDecode:  stateNext = hsAck;
      // hold results until the requester lets go
      hsAck:     if (!req) stateNext = hsRelease;
      hsRelease: stateNext = hsIdle;
      default:   stateNext = hsIdle;
    endcase
  end

  // outputs follow the state they enter, so they line up with it
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state     <= hsIdle;
      ack       <= 1'b0;
      calcEn    <= 1'b0;
      rasUpdate <= 1'b0;
    end else begin
      state     <= stateNext;
      ack       <= (stateNext == hsAck);
      calcEn    <= (stateNext == hsDecode);
      rasUpdate <= (stateNext == hsDecode);
    end
  end

  // capture request on the latch edge
  always_ff @(posedge clk) begin
    if ((state == hsIdle) && req) begin
      pcReg     <= pcIn;
      instrReg  <= instrIn;
      mode64Reg <= mode64In;
    end
  end

endmodule

//--- design/jumpUnit.sv
`timescale 1ns/100ps

module jumpUnit (
  input  logic                           clk,
  input  logic                           arstN,
  input  logic                           req,
  input  jumpCorePkg::addrT              pc,
  input  logic [riscvIsaPkg::instrW-1:0] instr,
  input  logic                           mode64,
  output logic                           ack,
  output logic                           isJump,
  output jumpCorePkg::jumpKindT          jumpKind,
  output jumpCorePkg::addrT              target,
  output logic                           targetValid,
  output jumpCorePkg::addrT              linkAddr,
  output logic                           isCall,
  output logic                           isReturn
);
  import riscvIsaPkg::*;
  import jumpCorePkg::*;

  logic              calcEn;
  logic              rasUpdate;
  addrT              pcReg;
  logic [instrW-1:0] instrReg;
  logic              mode64Reg;
  jumpKindT          decKind;
  addrT              decImm;
  logic              decCall;
  logic              decReturn;
  logic              decCompressed;
  addrT              linkNext;
  addrT              rasTop;
  logic              rasEmpty;

  jumpHandshake hs0 (
    .clk       (clk),
    .arstN     (arstN),
    .req       (req),
    .pcIn      (pc),
    .instrIn   (instr),
    .mode64In  (mode64),
    .ack       (ack),
    .calcEn    (calcEn),
    .rasUpdate (rasUpdate),
    .pcReg     (pcReg),
    .instrReg  (instrReg),
    .mode64Reg (mode64Reg)
  );

  jumpDecoder dec0 (
    .instr      (instrReg),
    .mode64     (mode64Reg),
    .kind       (decKind),
    .imm        (decImm),
    .isCall     (decCall),
    .isReturn   (decReturn),
    .compressed (decCompressed)
  );

  // sees the stack top from before this update
  targetCalc calc0 (
    .clk         (clk),
    .arstN       (arstN),
    .calcEn      (calcEn),
    .pc          (pcReg),
    .kind        (decKind),
    .imm         (decImm),
    .isCall      (decCall),
    .isReturn    (decReturn),
    .compressed  (decCompressed),
    .rasTop      (rasTop),
    .rasEmpty    (rasEmpty),
    .isJump      (isJump),
    .targetValid (targetValid),
    .isCallOut   (isCall),
    .isReturnOut (isReturn),
    .jumpKindOut (jumpKind),
    .target      (target),
    .linkAddr    (linkAddr),
    .linkNext    (linkNext)
  );

  returnStack ras0 (
    .clk      (clk),
    .arstN    (arstN),
    .update   (rasUpdate),
    .push     (decCall),
    .pop      (decReturn),
    .pushAddr (linkNext),
    .top      (rasTop),
    .empty    (rasEmpty)
  );

endmodule

//--- design/returnStack.sv
`timescale 1ns/100ps

module returnStack (
  input  logic              clk,
  input  logic              arstN,
  input  logic              update,
  input  logic              push,
  input  logic              pop,
  input  jumpCorePkg::addrT pushAddr,
  output jumpCorePkg::addrT top,
  output logic              empty
);
  import jumpCorePkg::*;

  addrT               entries [rasDepth];
  logic [rasPtrW-1:0] topPtr;
  logic [rasPtrW:0]   count;
  logic               doPop;

  assign empty = (count == '0);
  assign top   = entries[topPtr];

  // popping an empty stack is ignored
  assign doPop = pop && !empty;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      topPtr <= '0;
      count  <= '0;
    end else if (update) begin
      if (push && !doPop) begin
        // pointer wraps, oldest entry gets overwritten when full
        topPtr <= topPtr + 1'b1;
        if (count != (rasPtrW+1)'(rasDepth)) begin
          count <= count + 1'b1;
        end
      end else if (doPop && !push) begin
        topPtr <= topPtr - 1'b1;
        count  <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (update && push) begin
      if (doPop) begin
        // replace top in place
        entries[topPtr] <= pushAddr;
      end else begin
        entries[topPtr + 1'b1] <= pushAddr;
      end
    end
  end

endmodule

//--- design/riscvIsaPkg.sv
package riscvIsaPkg;

  // base instruction word
  localparam int instrW = 32;

  // major opcodes of the control transfer group
  typedef enum logic [6:0] {
    opBranch = 7'b1100011,
    opJalr   = 7'b1100111,
    opJal    = 7'b1101111
  } opcodeT;

  // funct3 of the conditional branches
  typedef enum logic [2:0] {
    f3Beq  = 3'b000,
    f3Bne  = 3'b001,
    f3Blt  = 3'b100,
    f3Bge  = 3'b101,
    f3Bltu = 3'b110,
    f3Bgeu = 3'b111
  } brFunct3T;

  // jalr has a single legal funct3
  localparam logic [2:0] jalrFunct3 = 3'b000;

  // low two bits select the quadrant, 2'b11 means a full 32-bit word
  localparam logic [1:0] quadC1   = 2'b01;
  localparam logic [1:0] quadC2   = 2'b10;
  localparam logic [1:0] quadFull = 2'b11;

  // compressed funct3 in bits 15:13
  // cJal is quadrant 1 (RV32 only), cJrMv is quadrant 2
  typedef enum logic [2:0] {
    cJal  = 3'b001,
    cJrMv = 3'b100,
    cJ    = 3'b101,
    cBeqz = 3'b110,
    cBnez = 3'b111
  } cFunct3T;

  // ra and the alternate link register t0
  localparam logic [4:0] linkRegA = 5'd1;
  localparam logic [4:0] linkRegB = 5'd5;

endpackage

//--- design/targetCalc.sv
`timescale 1ns/100ps

module targetCalc (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  calcEn,
  input  jumpCorePkg::addrT     pc,
  input  jumpCorePkg::jumpKindT kind,
  input  jumpCorePkg::addrT     imm,
  input  logic                  isCall,
  input  logic                  isReturn,
  input  logic                  compressed,
  input  jumpCorePkg::addrT     rasTop,
  input  logic                  rasEmpty,
  output logic                  isJump,
  output logic                  targetValid,
  output logic                  isCallOut,
  output logic                  isReturnOut,
  output jumpCorePkg::jumpKindT jumpKindOut,
  output jumpCorePkg::addrT     target,
  output jumpCorePkg::addrT     linkAddr,
  output jumpCorePkg::addrT     linkNext
);
  import jumpCorePkg::*;

  addrT targetNext;
  logic validNext;

  // also feeds the stack push
  assign linkNext = compressed ? pc + addrT'(2) : pc + addrT'(4);

  always_comb begin
    targetNext = '0;
    validNext  = 1'b0;
    if (kind == jkJalr) begin
      // register target unknown, unless the stack has a prediction
      if (isReturn && !rasEmpty) begin
        targetNext = rasTop;
        validNext  = 1'b1;
      end
    end else if (kind != jkNone) begin
      targetNext = pc + imm;
      validNext  = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      isJump      <= 1'b0;
      targetValid <= 1'b0;
      isCallOut   <= 1'b0;
      isReturnOut <= 1'b0;
      jumpKindOut <= jkNone;
    end else if (calcEn) begin
      isJump      <= (kind != jkNone);
      targetValid <= validNext;
      isCallOut   <= isCall;
      isReturnOut <= isReturn;
      jumpKindOut <= kind;
    end
  end

  always_ff @(posedge clk) begin
    if (calcEn) begin
      target   <= targetNext;
      linkAddr <= (kind == jkNone) ? '0 : linkNext;
    end
  end

endmodule

//--- jumpUnit.f
design/riscvIsaPkg.sv
design/jumpCorePkg.sv
design/jumpDecoder.sv
design/returnStack.sv
design/targetCalc.sv
design/jumpHandshake.sv
design/jumpUnit.sv
sim/jumpUnitTb.sv

//--- sim/jumpUnitTb.sv
`timescale 1ns/100ps

module jumpUnitTb;
  import riscvIsaPkg::*;
  import jumpCorePkg::*;

  // ack is seen on the third falling edge after req is driven
  // the unit latches on the next rising edge and answers one edge later
  localparam int ackNegedges    = 3;
  localparam int ackTimeout     = 50;
  localparam int releaseTimeout = 20;

  typedef struct packed {
    addrT              pc;
    logic [instrW-1:0] word;
    logic              mode64;
    logic              isJump;
    jumpKindT          kind;
    addrT              target;
    logic              targetValid;
    addrT              link;
    logic              call;
    logic              ret;
  } rowT;

  logic              clk;
  logic              arstN;
  logic              req;
  addrT              pc;
  logic [instrW-1:0] instr;
  logic              mode64;
  logic              ack;
  logic              isJump;
  jumpKindT          jumpKind;
  addrT              target;
  logic              targetValid;
  addrT              linkAddr;
  logic              isCall;
  logic              isReturn;

  rowT rows[$];

  jumpUnit dut0 (
    .clk         (clk),
    .arstN       (arstN),
    .req         (req),
    .pc          (pc),
    .instr       (instr),
    .mode64      (mode64),
    .ack         (ack),
    .isJump      (isJump),
    .jumpKind    (jumpKind),
    .target      (target),
    .targetValid (targetValid),
    .linkAddr    (linkAddr),
    .isCall      (isCall),
    .isReturn    (isReturn)
  );

  always #10 clk = ~clk;

  function automatic addrT signExt(input int v);
    return {{32{v[31]}}, v};
  endfunction

  // instruction encoders
  // branches use rs1 = x10 and rs2 = x11
  function automatic logic [31:0] encBranch(input logic [2:0] f3, input int off);
    logic [12:0] i;
    i = off[12:0];
    return {i[12], i[10:5], 5'd11, 5'd10, f3, i[4:1], i[11], opBranch};
  endfunction

  function automatic logic [31:0] encJal(input logic [4:0] rd, input int off);
    logic [20:0] i;
    i = off[20:0];
    return {i[20], i[10:1], i[11], i[19:12], rd, opJal};
  endfunction

  function automatic logic [31:0] encJalr(input logic [4:0] rd, input logic [4:0] rs1,
                                          input int off);
    return {off[11:0], rs1, 3'b000, rd, opJalr};
  endfunction

  // C.J and C.JAL
  function automatic logic [31:0] encCj(input logic [2:0] f3, input int off);
    logic [11:0] i;
    i = off[11:0];
    return {16'h0, f3, i[11], i[4], i[9:8], i[10], i[6], i[7], i[3:1], i[5], 2'b01};
  endfunction

  // C.BEQZ and C.BNEZ with the 3-bit compressed register rs1p
  function automatic logic [31:0] encCb(input logic [2:0] f3, input logic [2:0] rs1p,
                                        input int off);
    logic [8:0] i;
    i = off[8:0];
    return {16'h0, f3, i[8], i[4:3], rs1p, i[7:6], i[2:1], i[5], 2'b01};
  endfunction

  // C.JR when link is 0 and C.JALR when link is 1
  function automatic logic [31:0] encCjr(input logic link, input logic [4:0] rs1);
    return {16'h0, cJrMv, link, rs1, 5'd0, 2'b10};
  endfunction

  task automatic checkKind(input string name, input jumpKindT got, input jumpKindT exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %s, expected %s", $time, name, got.name(),
               exp.name());
      $display("*** TEST FAILED ***");
      $fatal(1, "jump kind mismatch");
    end
  endtask

  task automatic checkAddr(input string name, input addrT got, input addrT exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "flag mismatch");
    end
  endtask

  // expected link is pc plus length or zero for a non-jump
  task automatic addRow(input addrT pcV, input logic [31:0] word, input logic m64,
                        input jumpKindT kind, input addrT tgt, input logic tv,
                        input int len, input logic call, input logic ret);
    rowT r;
    r.pc          = pcV;
    r.word        = word;
    r.mode64      = m64;
    r.isJump      = (kind != jkNone);
    r.kind        = kind;
    r.target      = tgt;
    r.targetValid = tv;
    r.link        = (kind == jkNone) ? '0 : pcV + addrT'(len);
    r.call        = call;
    r.ret         = ret;
    rows.push_back(r);
  endtask

  task automatic buildTable();
    addrT b;
    addrT q;
    addrT links[9];
    // six branches leave the stack empty
    b = 64'h0000_0040_8000_1000;
    addRow(b, encBranch(f3Beq, 64), 0, jkBeq, b + signExt(64), 1, 4, 0, 0);
    addRow(b + 'h10, encBranch(f3Bne, -128), 0, jkBne, b + 'h10 + signExt(-128), 1, 4, 0, 0);
    addRow(b + 'h20, encBranch(f3Blt, 2046), 0, jkBlt, b + 'h20 + signExt(2046), 1, 4, 0, 0);
    addRow(b + 'h30, encBranch(f3Bge, -4096), 0, jkBge, b + 'h30 + signExt(-4096), 1, 4, 0, 0);
    addRow(b + 'h40, encBranch(f3Bltu, 12), 0, jkBltu, b + 'h40 + signExt(12), 1, 4, 0, 0);
    addRow(b + 'h50, encBranch(f3Bgeu, -6), 0, jkBgeu, b + 'h50 + signExt(-6), 1, 4, 0, 0);

    // JAL and C.JAL calls and then RV64 C.JAL and C.J before draining the two links
    b = 64'h0000_0000_8000_2000;
    q = b + 'h20;
    addRow(b, encJal(linkRegA, 2048), 0, jkJal, b + signExt(2048), 1, 4, 1, 0);
    addRow(q, encCj(cJal, 100), 0, jkJal, q + signExt(100), 1, 2, 1, 0);
    addRow(q + 'h10, encCj(cJal, 100), 1, jkNone, '0, 0, 2, 0, 0);
    addRow(q + 'h20, encCj(cJ, -2048), 0, jkJal, q + 'h20 + signExt(-2048), 1, 2, 0, 0);
    addRow(b + 'h100, encJalr(5'd0, linkRegA, 0), 0, jkJalr, q + 2, 1, 4, 0, 1);
    addRow(b + 'h104, encCjr(1'b0, linkRegA), 0, jkJalr, b + 4, 1, 2, 0, 1);

    // three calls and three returns and then one return on an empty stack
    b = 64'h0000_0000_9000_0000;
    addRow(b, encJal(linkRegA, 256), 0, jkJal, b + signExt(256), 1, 4, 1, 0);
    addRow(b + 'h100, encCj(cJal, -20), 0, jkJal, b + 'h100 + signExt(-20), 1, 2, 1, 0);
    addRow(b + 'h200, encJalr(linkRegA, 5'd10, 8), 0, jkJalr, '0, 0, 4, 1, 0);
    addRow(b + 'h300, encJalr(5'd0, linkRegA, 0), 0, jkJalr, b + 'h204, 1, 4, 0, 1);
    addRow(b + 'h304, encCjr(1'b0, linkRegA), 0, jkJalr, b + 'h102, 1, 2, 0, 1);
    addRow(b + 'h306, encJalr(5'd0, linkRegB, 0), 0, jkJalr, b + 4, 1, 4, 0, 1);
    addRow(b + 'h310, encCjr(1'b0, linkRegA), 0, jkJalr, '0, 0, 2, 0, 1);

    // nine calls overflow the stack and lose the oldest link
    b = 64'h0000_0000_a000_0000;
    for (int k = 0; k < 9; k++) begin
      q = b + addrT'(k * 'h40);
      links[k] = q + 4;
      addRow(q, encJal(linkRegA, 32), 0, jkJal, q + 32, 1, 4, 1, 0);
    end
    for (int k = 0; k < 8; k++) begin
      q = b + 'h1000 + addrT'(k * 4);
      addRow(q, encJalr(5'd0, linkRegA, 0), 0, jkJalr, links[8 - k], 1, 4, 0, 1);
    end
    addRow(b + 'h1100, encJalr(5'd0, linkRegA, 0), 0, jkJalr, '0, 0, 4, 0, 1);

    // a combined return and call replaces the top, so one return empties the stack
    b = 64'h0000_0012_3456_7000;
    addRow(b, encJal(linkRegA, -1024), 0, jkJal, b + signExt(-1024), 1, 4, 1, 0);
    addRow(b + 'h80, encJalr(linkRegA, linkRegB, 16), 0, jkJalr, b + 4, 1, 4, 1, 1);
    addRow(b + 'h100, encJalr(5'd0, linkRegA, 0), 0, jkJalr, b + 'h84, 1, 4, 0, 1);
    addRow(b + 'h104, encCjr(1'b0, linkRegA), 0, jkJalr, '0, 0, 2, 0, 1);
    addRow(b + 'h200, encCb(cBeqz, 3'd0, 70), 0, jkBeq, b + 'h200 + signExt(70), 1, 2, 0, 0);
    addRow(b + 'h202, encCb(cBnez, 3'd1, -40), 0, jkBne, b + 'h202 + signExt(-40), 1, 2, 0, 0);

    // addi x0, x0, 0
    addRow(64'h0000_0000_8000_4000, 32'h0000_0013, 0, jkNone, '0, 0, 4, 0, 0);
  endtask

  task automatic waitForAck(input logic level, input int limit, output int waited);
    waited = 1;
    @(negedge clk);
    while ((ack !== level) && (waited < limit)) begin
      @(negedge clk);
      waited = waited + 1;
    end
    if (ack !== level) begin
      $display("Timed out waiting for ack to go %s", level ? "high" : "low");
      $display("*** TEST FAILED ***");
      $fatal(1, "handshake timeout");
    end
  endtask

  // one full four-phase exchange
  task automatic applyRow(input rowT r);
    int waited;
    @(posedge clk);
    pc     <= r.pc;
    instr  <= r.word;
    mode64 <= r.mode64;
    req    <= 1'b1;
    waitForAck(1'b1, ackTimeout, waited);
    if (waited != ackNegedges) begin
      $display("ack did not rise one cycle after the latch edge for pc %h", r.pc);
      $display("*** TEST FAILED ***");
      $fatal(1, "ack latency");
    end
    checkFlag("isJump", isJump, r.isJump);
    checkKind("jumpKind", jumpKind, r.kind);
    checkAddr("target", target, r.target);
    checkFlag("targetValid", targetValid, r.targetValid);
    checkAddr("linkAddr", linkAddr, r.link);
    checkFlag("isCall", isCall, r.call);
    checkFlag("isReturn", isReturn, r.ret);
    @(posedge clk);
    req <= 1'b0;
    waitForAck(1'b0, releaseTimeout, waited);
  endtask

  initial begin
    clk    = 1'b0;
    arstN  <= 1'b0;
    req    <= 1'b0;
    pc     <= '0;
    instr  <= '0;
    mode64 <= 1'b0;
    buildTable();
    repeat (16) @(posedge clk);
    arstN <= 1'b1;
    // idle unit must keep ack low while req stays low
    repeat (4) begin
      @(negedge clk);
      checkFlag("ack", ack, 1'b0);
      checkFlag("isJump", isJump, 1'b0);
      checkFlag("targetValid", targetValid, 1'b0);
      checkFlag("isCall", isCall, 1'b0);
      checkFlag("isReturn", isReturn, 1'b0);
    end
    foreach (rows[i]) begin
      applyRow(rows[i]);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
